//--- list.f
uart_pkg.sv
uart_chan_if.sv
uart_axil_regs.sv
uart_tx_fsm.sv
uart_tx_channel.sv
uart_tx_status.sv
uart_tx_top.sv
uart_tx_properties.sv
tb_uart_tx.sv

//--- run.sh
#!/usr/bin/env bash
# Build the UART transmitter testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_uart_tx -f list.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "All tests passed" &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }

//--- tb_uart_tx.sv
/*
 * Directed testbench for the four-channel UART transmitter
 * AXI4-Lite driver, serial-line decoder, LFSR data and cycle timeout
 */
`timescale 1ns/1ns

module tb_uart_tx;
  import uart_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;  // About 20 frames of 224 cycles, four times over

  logic        clk_i, rst_i;
  addr_t       awaddr, araddr;
  word_t       wdata, rdata;
  logic        awvalid, awready, wvalid, wready, bvalid, bready;
  logic        arvalid, arready, rvalid, rready;
  logic [1:0]  bresp, rresp;
  ch_mask_t    tx;
  logic        irq;
  logic [31:0] lfsr_q;
  int          cycles = 0;
  string       test_name;

  uart_tx_top uut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .s_awaddr_i  (awaddr),
    .s_awvalid_i (awvalid),
    .s_awready_o (awready),
    .s_wdata_i   (wdata),
    .s_wvalid_i  (wvalid),
    .s_wready_o  (wready),
    .s_bresp_o   (bresp),
    .s_bvalid_o  (bvalid),
    .s_bready_i  (bready),
    .s_araddr_i  (araddr),
    .s_arvalid_i (arvalid),
    .s_arready_o (arready),
    .s_rdata_o   (rdata),
    .s_rresp_o   (rresp),
    .s_rvalid_o  (rvalid),
    .s_rready_i  (rready),
    .tx_o        (tx),
    .irq_o       (irq)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) fail_run("Timeout, the DUT did not finish in time");
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input byte_t exp, input byte_t act);
    if (act !== exp) fail_run($sformatf("ERR %s exp=%02h act=%02h", test_name, exp, act));
  endtask

  task automatic check_bit(input logic exp, input logic act);
    if (act !== exp) fail_run($sformatf("ERR %s exp=%b act=%b", test_name, exp, act));
  endtask

  task automatic check_mask(input ch_mask_t exp, input ch_mask_t act);
    if (act !== exp) fail_run($sformatf("ERR %s exp=%h act=%h", test_name, exp, act));
  endtask

  task automatic check_word(input word_t exp, input word_t act);
    if (act !== exp) fail_run($sformatf("ERR %s exp=%08h act=%08h", test_name, exp, act));
  endtask

  task automatic check_resp(input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) fail_run($sformatf("ERR %s exp=%b act=%b", test_name, exp, act));
  endtask

  // Galois form, taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_byte(output byte_t b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_step(lfsr_q);  // One step per bit
      b = {b[6:0], lfsr_q[0]};
    end
  endtask

  function automatic addr_t data_addr(input int c);
    return ADDR_DATA0 + addr_t'(4 * c);  // Data registers one word apart
  endfunction

  task automatic axil_write(input addr_t addr, input word_t data, output logic [1:0] resp);
    @(posedge clk_i);
    #2;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do begin
      @(posedge clk_i);
      #2;
    end while (awready !== 1'b1 || wready !== 1'b1);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    while (bvalid !== 1'b1) begin
      @(posedge clk_i);
      #2;
    end
    resp = bresp;
    @(posedge clk_i);
    #2;
    bready = 1'b0;
  endtask

  task automatic axil_read(input addr_t addr, output word_t data, output logic [1:0] resp);
    @(posedge clk_i);
    #2;
    araddr  = addr;    // Held until the data is captured
    arvalid = 1'b1;
    do begin
      @(posedge clk_i);
      #2;
    end while (arready !== 1'b1);
    arvalid = 1'b0;
    rready  = 1'b1;
    while (rvalid !== 1'b1) begin
      @(posedge clk_i);
      #2;
    end
    data = rdata;
    resp = rresp;
    @(posedge clk_i);
    #2;
    rready = 1'b0;
  endtask

  // Finds the falling start edge, then samples every bit at its middle
  task automatic decode_frame(input int ch, input logic has_par, output byte_t data,
                              output logic par);
    logic prev, cur;
    data = '0;
    par  = 1'b0;
    cur  = tx[ch];
    do begin
      prev = cur;
      @(posedge clk_i);
      #1;
      cur = tx[ch];
    end while (!(prev === 1'b1 && cur === 1'b0));
    repeat (CLKS_PER_BIT / 2) @(posedge clk_i);
    #1;
    if (tx[ch] !== 1'b0) fail_run($sformatf("Start bit on channel %0d did not stay low", ch));
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(posedge clk_i);
      #1;
      data[i] = tx[ch];    // LSB first
    end
    if (has_par) begin
      repeat (CLKS_PER_BIT) @(posedge clk_i);
      #1;
      par = tx[ch];
    end
    repeat (CLKS_PER_BIT) @(posedge clk_i);
    #1;
    if (tx[ch] !== 1'b1) fail_run($sformatf("Stop bit on channel %0d was not high", ch));
  endtask

  task automatic reset_state();
    word_t      rd;
    logic [1:0] resp;
    test_name = "reset_state";
    check_mask('1, tx);
    check_bit(1'b0, irq);
    axil_read(ADDR_STAT, rd, resp);
    check_resp(RESP_OKAY, resp);
    check_word('0, rd);
  endtask

  // Parity mode 0 is off, 1 even, 2 odd
  task automatic frames_on_each_channel(input int mode);
    byte_t      sent, got;
    logic       par;
    logic [1:0] resp;
    test_name = (mode == 0) ? "plain_frames" : (mode == 1) ? "even_parity" : "odd_parity";
    axil_write(ADDR_CTRL, word_t'({mode == 2, mode != 0}), resp);
    check_resp(RESP_OKAY, resp);
    for (int c = 0; c < NUM_CH; c++) begin
      rand_byte(sent);
      fork
        decode_frame(c, mode != 0, got, par);
        axil_write(data_addr(c), word_t'(sent), resp);
      join
      check_resp(RESP_OKAY, resp);
      check_byte(sent, got);
      if (mode != 0) check_bit((mode == 2) ? ~(^sent) : ^sent, par);
    end
    axil_write(ADDR_CTRL, '0, resp);
    check_resp(RESP_OKAY, resp);
  endtask

  task automatic busy_write();
    byte_t      first, got;
    logic       par;
    logic [1:0] resp1, resp2;
    word_t      rd;
    test_name = "busy_write";
    rand_byte(first);
    fork
      decode_frame(1, 1'b0, got, par);
      begin
        axil_write(ADDR_DATA1, word_t'(first), resp1);
        axil_write(ADDR_DATA1, word_t'(~first), resp2);  // Lands mid-frame
      end
    join
    check_resp(RESP_OKAY, resp1);
    check_resp(RESP_SLVERR, resp2);
    check_byte(first, got);
    axil_read(8'h20, rd, resp1);
    check_resp(RESP_SLVERR, resp1);
  endtask

  task automatic done_irq();
    byte_t      b0, b2, got0, got2;
    logic       par0, par2;
    logic [1:0] resp;
    word_t      rd;
    ch_mask_t   chosen;
    test_name = "done_irq";
    chosen = 4'b0101;
    axil_write(ADDR_STAT, word_t'({ch_mask_t'('1), ch_mask_t'(0)}), resp);  // Clear older bits
    check_resp(RESP_OKAY, resp);
    axil_read(ADDR_STAT, rd, resp);
    check_resp(RESP_OKAY, resp);
    check_word('0, rd);
    check_bit(1'b0, irq);
    rand_byte(b0);
    rand_byte(b2);
    fork
      decode_frame(0, 1'b0, got0, par0);
      decode_frame(2, 1'b0, got2, par2);
      begin
        axil_write(ADDR_DATA0, word_t'(b0), resp);
        check_resp(RESP_OKAY, resp);
        axil_write(ADDR_DATA2, word_t'(b2), resp);
        check_resp(RESP_OKAY, resp);
      end
    join
    check_byte(b0, got0);
    check_byte(b2, got2);
    axil_read(ADDR_STAT, rd, resp);
    check_resp(RESP_OKAY, resp);
    check_mask(chosen, rd[7:4]);
    check_word(word_t'({chosen, ch_mask_t'(0)}), rd);
    check_bit(1'b1, irq);
    axil_write(ADDR_STAT, word_t'({ch_mask_t'('1), ch_mask_t'(0)}), resp);
    check_resp(RESP_OKAY, resp);
    axil_read(ADDR_STAT, rd, resp);
    check_resp(RESP_OKAY, resp);
    check_word('0, rd);
    check_bit(1'b0, irq);
  endtask

  task automatic concurrent_frames();
    byte_t      sent [NUM_CH];
    byte_t      got [NUM_CH];
    logic       par [NUM_CH];
    logic [1:0] resp [NUM_CH];
    logic [1:0] rresp_s;
    word_t      rd;
    test_name = "concurrent_frames";
    for (int c = 0; c < NUM_CH; c++) rand_byte(sent[c]);
    fork
      decode_frame(0, 1'b0, got[0], par[0]);
      decode_frame(1, 1'b0, got[1], par[1]);
      decode_frame(2, 1'b0, got[2], par[2]);
      decode_frame(3, 1'b0, got[3], par[3]);
      begin
        for (int c = 0; c < NUM_CH; c++) axil_write(data_addr(c), word_t'(sent[c]), resp[c]);
        axil_read(ADDR_STAT, rd, rresp_s);
        check_resp(RESP_OKAY, rresp_s);
        check_word(word_t'({ch_mask_t'(0), ch_mask_t'('1)}), rd);  // All busy at once
      end
    join
    for (int c = 0; c < NUM_CH; c++) begin
      check_resp(RESP_OKAY, resp[c]);
      check_byte(sent[c], got[c]);
    end
  endtask

  initial begin
    rst_i   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    lfsr_q  = 32'hc4ae;
    repeat (2) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    reset_state();
    frames_on_each_channel(0);
    frames_on_each_channel(1);
    frames_on_each_channel(2);
    busy_write();
    done_irq();
    concurrent_frames();
    $display("All tests passed");
    $finish;
  end

endmodule

//--- uart_axil_regs.sv
/*
 * AXI4-Lite register block for the UART transmitter
 * Turns data writes into channel starts, holds parity control, serves status
 */
`timescale 1ns/1ns

module uart_axil_regs (
  input  logic                clk_i,
  input  logic                rst_i,
  input  uart_pkg::addr_t     s_awaddr_i,
  input  logic                s_awvalid_i,
  output logic                s_awready_o,
  input  uart_pkg::word_t     s_wdata_i,
  input  logic                s_wvalid_i,
  output logic                s_wready_o,
  output logic [1:0]          s_bresp_o,
  output logic                s_bvalid_o,
  input  logic                s_bready_i,
  input  uart_pkg::addr_t     s_araddr_i,
  input  logic                s_arvalid_i,
  output logic                s_arready_o,
  output uart_pkg::word_t     s_rdata_o,
  output logic [1:0]          s_rresp_o,
  output logic                s_rvalid_o,
  input  logic                s_rready_i,
  uart_chan_if.regs           ch [uart_pkg::NUM_CH],
  input  uart_pkg::ch_mask_t  done_i,
  output uart_pkg::ch_mask_t  done_clr_o
);
  import uart_pkg::*;

  logic       aw_ready_q, b_valid_q, ar_ready_q, r_valid_q;
  logic [1:0] b_resp_q, r_resp_q;
  word_t      r_data_q, rd_word;
  logic       rd_ok;
  logic       par_en_q, par_odd_q;
  byte_t      data_q [NUM_CH];   // Last accepted character per channel
  ch_mask_t   start_q, done_clr_q, eot_vec, wr_sel, rd_sel, wr_start;
  logic       wr_fire, rd_fire;

  function automatic ch_mask_t data_sel(addr_t a);
    data_sel = {a == ADDR_DATA3, a == ADDR_DATA2, a == ADDR_DATA1, a == ADDR_DATA0};
  endfunction

  for (genvar g = 0; g < NUM_CH; g++) begin : g_link
    assign ch[g].start   = start_q[g];
    assign ch[g].data    = data_q[g];
    assign ch[g].par_en  = par_en_q;
    assign ch[g].par_odd = par_odd_q;
    assign eot_vec[g]    = ch[g].eot;
  end

  assign wr_fire  = s_awvalid_i & s_wvalid_i & ~aw_ready_q & ~b_valid_q;
  assign rd_fire  = s_arvalid_i & ~ar_ready_q & ~r_valid_q;
  assign wr_sel   = data_sel(s_awaddr_i);
  assign rd_sel   = data_sel(s_araddr_i);
  assign wr_start = wr_sel & eot_vec & {NUM_CH{wr_fire}};  // Busy channels ignore writes

  always_comb begin
    rd_word = '0;
    rd_ok   = 1'b1;
    if (|rd_sel) begin
      for (int i = 0; i < NUM_CH; i++) begin
        if (rd_sel[i]) rd_word = word_t'(data_q[i]);
      end
    end else if (s_araddr_i == ADDR_CTRL) begin
      rd_word = word_t'({par_odd_q, par_en_q});
    end else if (s_araddr_i == ADDR_STAT) begin
      rd_word = word_t'({done_i, ~eot_vec});          // Done above busy
    end else begin
      rd_ok = 1'b0;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      aw_ready_q <= 1'b0;
      b_valid_q  <= 1'b0;
      b_resp_q   <= RESP_OKAY;
      start_q    <= '0;
      done_clr_q <= '0;
      par_en_q   <= 1'b0;
      par_odd_q  <= 1'b0;
    end else begin
      aw_ready_q <= wr_fire;                           // AWREADY and WREADY pulse together
      start_q    <= wr_start;
      done_clr_q <= '0;
      if (wr_fire) begin
        if (|wr_sel) begin
          b_resp_q <= (|wr_start) ? RESP_OKAY : RESP_SLVERR;
        end else if (s_awaddr_i == ADDR_CTRL) begin
          par_en_q  <= s_wdata_i[CTRL_PAR_EN];
          par_odd_q <= s_wdata_i[CTRL_PAR_ODD];
          b_resp_q  <= RESP_OKAY;
        end else if (s_awaddr_i == ADDR_STAT) begin
          done_clr_q <= s_wdata_i[2*NUM_CH-1:NUM_CH];  // Write 1 to clear
          b_resp_q   <= RESP_OKAY;
        end else begin
          b_resp_q <= RESP_SLVERR;
        end
      end
      if (aw_ready_q) b_valid_q <= 1'b1;
      else if (s_bready_i) b_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (wr_start[i]) data_q[i] <= s_wdata_i[7:0];
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
      r_data_q   <= '0;
      r_resp_q   <= RESP_OKAY;
    end else begin
      ar_ready_q <= rd_fire;
      if (ar_ready_q) begin
        r_valid_q <= 1'b1;
        r_data_q  <= rd_word;
        r_resp_q  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
      end else if (s_rready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  assign s_awready_o = aw_ready_q;
  assign s_wready_o  = aw_ready_q;
  assign s_bvalid_o  = b_valid_q;
  assign s_bresp_o   = b_resp_q;
  assign s_arready_o = ar_ready_q;
  assign s_rvalid_o  = r_valid_q;
  assign s_rdata_o   = r_data_q;
  assign s_rresp_o   = r_resp_q;
  assign done_clr_o  = done_clr_q;

endmodule

//--- uart_chan_if.sv
/*
 * Per-channel link between register block, transmit channel and status block
 * Carries start pulse, character, parity settings and end-of-transmission
 */
`timescale 1ns/1ns

interface uart_chan_if;
  import uart_pkg::*;

  logic  start;    // One-cycle launch pulse
  byte_t data;
  logic  par_en;
  logic  par_odd;
  logic  eot;      // High while channel idle

  modport regs (
    output start, data, par_en, par_odd,
    input  eot
  );

  modport chan (
    input  start, data, par_en, par_odd,
    output eot
  );

  modport mon (
    input eot
  );

endinterface

//--- uart_pkg.sv
/*
 * UART transmitter shared definitions
 * Channel count, fixed bit period, register map, AXI responses and FSM states
 */
package uart_pkg;

  localparam int NUM_CH       = 4;
  localparam int CLKS_PER_BIT = 16;                    // Fixed baud rate
  localparam int BAUD_W       = $clog2(CLKS_PER_BIT);

  typedef logic [7:0]        byte_t;
  typedef logic [NUM_CH-1:0] ch_mask_t;
  typedef logic [3:0]        bit_sel_t;
  typedef logic [7:0]        addr_t;
  typedef logic [31:0]       word_t;

  localparam addr_t ADDR_DATA0 = 8'h00;
  localparam addr_t ADDR_DATA1 = 8'h04;
  localparam addr_t ADDR_DATA2 = 8'h08;
  localparam addr_t ADDR_DATA3 = 8'h0C;
  localparam addr_t ADDR_CTRL  = 8'h10;
  localparam addr_t ADDR_STAT  = 8'h14;

  localparam int CTRL_PAR_EN  = 0;                     // Control bit positions
  localparam int CTRL_PAR_ODD = 1;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic [3:0] {
    ST_IDLE, ST_SYNC, ST_START,
    ST_D0, ST_D1, ST_D2, ST_D3, ST_D4, ST_D5, ST_D6, ST_D7,
    ST_PAR
  } tx_state_e;

endpackage

//--- uart_tx_channel.sv
/*
 * One UART transmit channel
 * Baud timer, frame latch, parity, registered bit mux and sequencer
 */
`timescale 1ns/1ns

module uart_tx_channel (
  input  logic      clk_i,
  input  logic      rst_i,
  uart_chan_if.chan ch,
  output logic      tx_o
);
  import uart_pkg::*;

  logic [BAUD_W-1:0] baud_cnt_q;
  logic              tick;
  logic              fsm_eot, eot_q, accept;
  bit_sel_t          sel, data_idx;
  byte_t             data_q;
  logic              par_en_q, par_odd_q, par_bit;
  logic              tx_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) baud_cnt_q <= '0;
    else baud_cnt_q <= tick ? '0 : baud_cnt_q + 1'b1;  // Free running
  end

  assign tick   = (baud_cnt_q == BAUD_W'(CLKS_PER_BIT - 1));
  assign accept = ch.start & fsm_eot;

  // Frame settings frozen for the whole character
  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q    <= ch.data;
      par_en_q  <= ch.par_en;
      par_odd_q <= ch.par_odd;
    end
  end

  assign par_bit  = (^data_q) ^ par_odd_q;
  assign data_idx = sel - 4'd2;

  uart_tx_fsm u_fsm (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .sttx_i (ch.start),
    .z_i    (tick),
    .psel_i (par_en_q),
    .sel_o  (sel),
    .eot_o  (fsm_eot)
  );

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      tx_q  <= 1'b1;
      eot_q <= 1'b1;
    end else begin
      eot_q <= fsm_eot;                        // Aligned with the line
      case (sel)
        4'd0:    tx_q <= 1'b1;                 // Idle, stop, sync
        4'd1:    tx_q <= 1'b0;                 // Start bit
        4'd10:   tx_q <= par_bit;
        default: tx_q <= data_q[data_idx[2:0]];  // LSB first
      endcase
    end
  end

  assign ch.eot = eot_q;
  assign tx_o   = tx_q;

endmodule

//--- uart_tx_fsm.sv
/*
 * UART frame sequencer
 * Steps sync, start, D0 to D7 and optional parity on each baud tick
 */
`timescale 1ns/1ns

module uart_tx_fsm (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               sttx_i,   // Launch request
  input  logic               z_i,      // Baud tick
  input  logic               psel_i,   // Parity bit enabled
  output uart_pkg::bit_sel_t sel_o,    // Bit mux select
  output logic               eot_o     // Idle, frame finished
);
  import uart_pkg::*;

  tx_state_e state_q, state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (sttx_i) state_d = ST_SYNC;
      end
      ST_SYNC, ST_START, ST_D0, ST_D1, ST_D2, ST_D3, ST_D4, ST_D5, ST_D6: begin
        if (z_i) state_d = tx_state_e'(state_q + 4'd1);  // Next bit position
      end
      ST_D7: begin
        if (z_i) state_d = psel_i ? ST_PAR : ST_IDLE;
      end
      ST_PAR: begin
        if (z_i) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Select 0 keeps the line high, then start, data and parity follow in order
  always_comb begin
    case (state_q)
      ST_IDLE, ST_SYNC: sel_o = 4'd0;
      default:          sel_o = bit_sel_t'(state_q) - 4'd1;
    endcase
  end

  assign eot_o = (state_q == ST_IDLE);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- uart_tx_properties.sv
/*
 * Bound checks on the AXI4-Lite response channels, the serial lines
 * and channel starts
 */
`timescale 1ns/1ns

module uart_tx_properties (
  input logic               clk_i,
  input logic               rst_i,
  input logic               bvalid_i,
  input logic               bready_i,
  input logic               rvalid_i,
  input logic               rready_i,
  input uart_pkg::ch_mask_t tx_i,
  input uart_pkg::ch_mask_t eot_i,
  input uart_pkg::ch_mask_t start_i
);

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("BVALID fell before BREADY");

  a_rvalid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("RVALID fell before RREADY");

  // An idle channel must hold its line at the mark level
  a_idle_line_high: assert property (@(posedge clk_i) disable iff (rst_i)
    &(tx_i | ~eot_i))
    else $error("tx low on a channel whose eot is high");

  a_no_busy_start: assert property (@(posedge clk_i) disable iff (rst_i)
    ~|(start_i & ~eot_i))
    else $error("start issued to a busy channel");

endmodule

bind uart_tx_top uart_tx_properties u_props (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .bvalid_i (s_bvalid_o),
  .bready_i (s_bready_i),
  .rvalid_i (s_rvalid_o),
  .rready_i (s_rready_i),
  .tx_i     (tx_o),
  .eot_i    (u_regs.eot_vec),
  .start_i  (u_regs.start_q)
);

//--- uart_tx_status.sv
/*
 * Transmit completion tracker
 * Sticky done bit per channel on eot rise, ORed into a registered interrupt
 */
`timescale 1ns/1ns

module uart_tx_status (
  input  logic               clk_i,
  input  logic               rst_i,
  uart_chan_if.mon           ch [uart_pkg::NUM_CH],
  input  uart_pkg::ch_mask_t done_clr_i,
  output uart_pkg::ch_mask_t done_o,
  output logic               irq_o
);
  import uart_pkg::*;

  ch_mask_t eot_vec, eot_q, done_q;
  logic     irq_q;

  for (genvar g = 0; g < NUM_CH; g++) begin : g_eot
    assign eot_vec[g] = ch[g].eot;
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      eot_q  <= '1;                                     // Channels idle from reset
      done_q <= '0;
      irq_q  <= 1'b0;
    end else begin
      eot_q  <= eot_vec;
      done_q <= (done_q & ~done_clr_i) | (eot_vec & ~eot_q);  // Set wins
      irq_q  <= |done_q;
    end
  end

  assign done_o = done_q;
  assign irq_o  = irq_q;

endmodule

//--- uart_tx_top.sv
/*
 * Four-channel UART transmitter with AXI4-Lite register port
 */
`timescale 1ns/1ns

module uart_tx_top (
  input  logic               clk_i,
  input  logic               rst_i,
  input  uart_pkg::addr_t    s_awaddr_i,
  input  logic               s_awvalid_i,
  output logic               s_awready_o,
  input  uart_pkg::word_t    s_wdata_i,
  input  logic               s_wvalid_i,
  output logic               s_wready_o,
  output logic [1:0]         s_bresp_o,
  output logic               s_bvalid_o,
  input  logic               s_bready_i,
  input  uart_pkg::addr_t    s_araddr_i,
  input  logic               s_arvalid_i,
  output logic               s_arready_o,
  output uart_pkg::word_t    s_rdata_o,
  output logic [1:0]         s_rresp_o,
  output logic               s_rvalid_o,
  input  logic               s_rready_i,
  output uart_pkg::ch_mask_t tx_o,
  output logic               irq_o
);
  import uart_pkg::*;

  ch_mask_t done, done_clr;

  uart_chan_if chan_bus [NUM_CH] ();

  uart_axil_regs u_regs (
    .clk_i, .rst_i,
    .s_awaddr_i, .s_awvalid_i, .s_awready_o,
    .s_wdata_i, .s_wvalid_i, .s_wready_o,
    .s_bresp_o, .s_bvalid_o, .s_bready_i,
    .s_araddr_i, .s_arvalid_i, .s_arready_o,
    .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
    .ch         (chan_bus),
    .done_i     (done),
    .done_clr_o (done_clr)
  );

  for (genvar g = 0; g < NUM_CH; g++) begin : g_chan
    uart_tx_channel u_chan (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .ch    (chan_bus[g]),
      .tx_o  (tx_o[g])
    );
  end

  uart_tx_status u_status (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ch         (chan_bus),
    .done_clr_i (done_clr),
    .done_o     (done),
    .irq_o      (irq_o)
  );

endmodule
